//--- rv_pkg.sv
package rv_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // Major opcodes, RV32I base
  localparam logic [6:0] OP_LOAD     = 7'b00_000_11;
  localparam logic [6:0] OP_STORE    = 7'b01_000_11;
  localparam logic [6:0] OP_BRANCH   = 7'b11_000_11;
  localparam logic [6:0] OP_JALR     = 7'b11_001_11;
  localparam logic [6:0] OP_MISC_MEM = 7'b00_011_11;
  localparam logic [6:0] OP_JAL      = 7'b11_011_11;
  localparam logic [6:0] OP_REG_IMM  = 7'b00_100_11;
  localparam logic [6:0] OP_REG_REG  = 7'b01_100_11;
  localparam logic [6:0] OP_ENVIRON  = 7'b11_100_11;
  localparam logic [6:0] OP_AUIPC    = 7'b00_101_11;
  localparam logic [6:0] OP_LUI      = 7'b01_101_11;

  localparam logic [6:0] FUNCT7_ALT = 7'b0100000; // SUB, SRA, SRAI

  // funct3 for ALU operations
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 for branches
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  localparam logic [2:0] F3_WORD = 3'b010; // LW and SW, the only widths kept
  localparam logic [2:0] F3_PRIV = 3'b000; // ECALL

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NEVER, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
  } br_cond_e;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } insn_r_t;

  typedef struct packed {
    logic [19:0] imm20;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } insn_uj_t;

  // Same 32-bit word seen as register fields or as the upper immediate
  typedef union packed {
    insn_r_t  r;
    insn_uj_t uj;
  } insn_u;

  typedef struct packed {
    alu_op_e   alu_op;
    br_cond_e  br_cond;
    logic      use_imm;  // B operand is imm
    logic      use_pc;   // A operand is the PC
    logic      is_jal;
    logic      is_jalr;
    logic      is_load;
    logic      is_store;
    logic      is_halt;
    logic      wb_en;
    word_t     imm;      // Sign-extended
    reg_addr_t rs1;      // Read indices, x0 when unused
    reg_addr_t rs2;
    reg_addr_t rd;
  } ctrl_t;

  typedef struct packed {
    logic      en;
    reg_addr_t addr;
    word_t     data;
  } rf_wr_t;

  typedef struct packed {
    word_t addr;
    word_t wdata;
    logic  we;
    logic  re;
  } dmem_req_t;

  typedef enum logic [1:0] {
    FETCH, EXEC, LOAD, HALTED
  } state_e;

endpackage

//--- rv_regfile.sv
module rv_regfile (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_addr_t rs1_addr,
  input  rv_pkg::reg_addr_t rs2_addr,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data,
  input  rv_pkg::rf_wr_t    wr
);
  import rv_pkg::*;

  word_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0; // x0 entry included and never written again
      end
    end else if (wr.en && wr.addr != '0) begin // Writes to x0 are dropped
      regs[wr.addr] <= wr.data;
    end
  end

  // Combinational read ports
  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

  // x0 reads as zero on both ports
  a_x0_zero : assert property (@(posedge clk) disable iff (rst)
    ((rs1_addr != '0) || (rs1_data == '0)) && ((rs2_addr != '0) || (rs2_data == '0)))
    else $error("x0 read back nonzero");

endmodule

//--- rv_decode.sv
module rv_decode (
  input  rv_pkg::insn_u insn,
  output rv_pkg::ctrl_t ctrl
);
  import rv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] f3;
  logic       alt;
  word_t      imm_i, imm_s, imm_b, imm_j, imm_u;
  alu_op_e    f3_alu_op;
  br_cond_e   f3_br_cond;

  assign opcode = insn.r.opcode;
  assign f3     = insn.r.funct3;
  assign alt    = (insn.r.funct7 == FUNCT7_ALT);

  // Immediates, register view for I/S/B and upper view for U/J
  assign imm_i = {{20{insn.r.funct7[6]}}, insn.r.funct7, insn.r.rs2};
  assign imm_s = {{20{insn.r.funct7[6]}}, insn.r.funct7, insn.r.rd};
  assign imm_b = {{19{insn.r.funct7[6]}}, insn.r.funct7[6], insn.r.rd[0],
                  insn.r.funct7[5:0], insn.r.rd[4:1], 1'b0};
  assign imm_j = {{12{insn.uj.imm20[19]}}, insn.uj.imm20[7:0], insn.uj.imm20[8],
                  insn.uj.imm20[18:9], 1'b0};
  assign imm_u = {insn.uj.imm20, 12'b0};

  always_comb begin
    case (f3)
      F3_ADD_SUB: f3_alu_op = (alt && opcode == OP_REG_REG) ? ALU_SUB : ALU_ADD; // ADDI has no SUBI
      F3_SLL:     f3_alu_op = ALU_SLL;
      F3_SLT:     f3_alu_op = ALU_SLT;
      F3_SLTU:    f3_alu_op = ALU_SLTU;
      F3_XOR:     f3_alu_op = ALU_XOR;
      F3_SRL_SRA: f3_alu_op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:      f3_alu_op = ALU_OR;
      default:    f3_alu_op = ALU_AND;
    endcase
  end

  always_comb begin
    case (f3)
      F3_BEQ:  f3_br_cond = BR_EQ;
      F3_BNE:  f3_br_cond = BR_NE;
      F3_BLT:  f3_br_cond = BR_LT;
      F3_BGE:  f3_br_cond = BR_GE;
      F3_BLTU: f3_br_cond = BR_LTU;
      F3_BGEU: f3_br_cond = BR_GEU;
      default: f3_br_cond = BR_NEVER; // Reserved encodings fall through
    endcase
  end

  always_comb begin
    ctrl         = '0; // No-op unless an opcode below claims it
    ctrl.alu_op  = ALU_ADD;
    ctrl.br_cond = BR_NEVER;
    ctrl.rd      = insn.r.rd;
    case (opcode)
      OP_LUI: begin // x0 + U-imm
        ctrl.use_imm = 1'b1;
        ctrl.imm     = imm_u;
        ctrl.wb_en   = 1'b1;
      end
      OP_AUIPC: begin
        ctrl.use_pc  = 1'b1;
        ctrl.use_imm = 1'b1;
        ctrl.imm     = imm_u;
        ctrl.wb_en   = 1'b1;
      end
      OP_REG_IMM: begin
        ctrl.alu_op  = f3_alu_op;
        ctrl.use_imm = 1'b1;
        ctrl.imm     = imm_i;
        ctrl.rs1     = insn.r.rs1;
        ctrl.wb_en   = 1'b1;
      end
      OP_REG_REG: begin
        ctrl.alu_op = f3_alu_op;
        ctrl.rs1    = insn.r.rs1;
        ctrl.rs2    = insn.r.rs2;
        ctrl.wb_en  = 1'b1;
      end
      OP_BRANCH: begin
        ctrl.br_cond = f3_br_cond;
        ctrl.imm     = imm_b;
        ctrl.rs1     = insn.r.rs1;
        ctrl.rs2     = insn.r.rs2;
      end
      OP_JAL: begin
        ctrl.is_jal = 1'b1;
        ctrl.imm    = imm_j;
        ctrl.wb_en  = 1'b1;
      end
      OP_JALR: begin
        ctrl.is_jalr = 1'b1;
        ctrl.use_imm = 1'b1;
        ctrl.imm     = imm_i;
        ctrl.rs1     = insn.r.rs1;
        ctrl.wb_en   = 1'b1;
      end
      OP_LOAD: begin
        if (f3 == F3_WORD) begin
          ctrl.is_load = 1'b1;
          ctrl.use_imm = 1'b1;
          ctrl.imm     = imm_i;
          ctrl.rs1     = insn.r.rs1;
          ctrl.wb_en   = 1'b1;
        end
      end
      OP_STORE: begin
        if (f3 == F3_WORD) begin
          ctrl.is_store = 1'b1;
          ctrl.use_imm  = 1'b1;
          ctrl.imm      = imm_s;
          ctrl.rs1      = insn.r.rs1;
          ctrl.rs2      = insn.r.rs2;
        end
      end
      OP_ENVIRON: begin // ECALL only, EBREAK and CSRs are no-ops
        ctrl.is_halt = (f3 == F3_PRIV) && (imm_i == '0);
      end
      default: ; // FENCE and unknown opcodes
    endcase
  end

endmodule

//--- rv_execute.sv
module rv_execute (
  input  rv_pkg::ctrl_t ctrl,
  input  rv_pkg::word_t pc,
  input  rv_pkg::word_t rs1_data,
  input  rv_pkg::word_t rs2_data,
  output rv_pkg::word_t alu_result,
  output rv_pkg::word_t next_pc,
  output rv_pkg::word_t link
);
  import rv_pkg::*;

  word_t      op_a, op_b;
  word_t      target;
  logic [4:0] shamt;
  logic       branch_taken;

  assign op_a  = ctrl.use_pc ? pc : rs1_data;
  assign op_b  = ctrl.use_imm ? ctrl.imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:  alu_result = op_a + op_b; // Also load/store address
      ALU_SUB:  alu_result = op_a - op_b;
      ALU_SLL:  alu_result = op_a << shamt;
      ALU_SLT:  alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:  alu_result = op_a ^ op_b;
      ALU_SRL:  alu_result = op_a >> shamt;
      ALU_SRA:  alu_result = $signed(op_a) >>> shamt;
      ALU_OR:   alu_result = op_a | op_b;
      default:  alu_result = op_a & op_b;
    endcase
  end

  // Branches always compare the two registers
  always_comb begin
    case (ctrl.br_cond)
      BR_EQ:   branch_taken = (rs1_data == rs2_data);
      BR_NE:   branch_taken = (rs1_data != rs2_data);
      BR_LT:   branch_taken = ($signed(rs1_data) < $signed(rs2_data));
      BR_GE:   branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
      BR_LTU:  branch_taken = (rs1_data < rs2_data);
      BR_GEU:  branch_taken = (rs1_data >= rs2_data);
      default: branch_taken = 1'b0;
    endcase
  end

  assign link   = pc + 32'd4;
  assign target = pc + ctrl.imm; // Branch and JAL target

  always_comb begin
    if (ctrl.is_jalr) begin
      next_pc = {alu_result[XLEN-1:1], 1'b0}; // rs1 + imm, bit 0 cleared
    end else if (ctrl.is_jal || branch_taken) begin
      next_pc = target;
    end else begin
      next_pc = link;
    end
  end

endmodule

//--- rv_sequencer.sv
module rv_sequencer (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::ctrl_t     ctrl,
  input  rv_pkg::word_t     alu_result,
  input  rv_pkg::word_t     next_pc,
  input  rv_pkg::word_t     link,
  input  rv_pkg::word_t     rs2_data,
  input  rv_pkg::word_t     dmem_rdata,
  output rv_pkg::word_t     pc,
  output rv_pkg::rf_wr_t    rf_wr,
  output rv_pkg::dmem_req_t dmem_req,
  output logic              retire,
  output logic              halt
);
  import rv_pkg::*;

  state_e state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= FETCH;
      pc    <= '0;
    end else begin
      case (state)
        FETCH: state <= EXEC; // imem word arrives on this edge
        EXEC: begin
          if (ctrl.is_load) begin
            state <= LOAD; // PC waits for the data word
          end else begin
            pc    <= next_pc;
            state <= ctrl.is_halt ? HALTED : FETCH;
          end
        end
        LOAD: begin
          pc    <= next_pc;
          state <= FETCH;
        end
        default: ; // HALTED holds until reset
      endcase
    end
  end

  assign retire = (state == EXEC && !ctrl.is_load) || (state == LOAD);
  assign halt   = (state == HALTED);

  // Memory strobes only in EXEC
  assign dmem_req.addr  = alu_result;
  assign dmem_req.wdata = rs2_data;
  assign dmem_req.we    = (state == EXEC) && ctrl.is_store;
  assign dmem_req.re    = (state == EXEC) && ctrl.is_load;

  always_comb begin
    rf_wr.en   = retire && ctrl.wb_en;
    rf_wr.addr = ctrl.rd;
    if (ctrl.is_jal || ctrl.is_jalr) begin
      rf_wr.data = link;
    end else if (state == LOAD) begin
      rf_wr.data = dmem_rdata;
    end else begin
      rf_wr.data = alu_result;
    end
  end

  // Strobes are exclusive and belong to EXEC
  a_dmem_strobe : assert property (@(posedge clk) disable iff (rst)
    (dmem_req.we || dmem_req.re) |-> (state == EXEC && !(dmem_req.we && dmem_req.re)))
    else $error("bad dmem strobe");

  a_pc_aligned : assert property (@(posedge clk) disable iff (rst)
    pc[1:0] == 2'b00)
    else $error("PC misaligned: %h", pc);

endmodule

//--- rv_perf_counters.sv
module rv_perf_counters (
  input  logic          clk,
  input  logic          rst,
  input  logic          halt,
  input  logic          retire,
  output rv_pkg::word_t cycle_count,
  output rv_pkg::word_t insn_count
);
  import rv_pkg::*;

  word_t cycle_next;
  word_t insn_next;

  assign cycle_next = halt ? cycle_count : cycle_count + 1'b1; // Frozen once halted
  assign insn_next  = retire ? insn_count + 1'b1 : insn_count;

  always_ff @(posedge clk) begin
    if (rst) begin
      cycle_count <= '0;
      insn_count  <= '0;
    end else begin
      cycle_count <= cycle_next;
      insn_count  <= insn_next;
    end
  end

  // Retires never outrun cycles
  a_insn_le_cycle : assert property (@(posedge clk) disable iff (rst)
    insn_count <= cycle_count)
    else $error("insn_count %0d above cycle_count %0d", insn_count, cycle_count);

endmodule

//--- rv_core.sv
module rv_core (
  input  logic              clk,
  input  logic              rst,
  output rv_pkg::word_t     imem_addr,
  input  rv_pkg::word_t     imem_rdata,
  output rv_pkg::dmem_req_t dmem_req,
  input  rv_pkg::word_t     dmem_rdata,
  output logic              halt,
  output rv_pkg::word_t     cycle_count,
  output rv_pkg::word_t     insn_count
);
  import rv_pkg::*;

  insn_u  insn;
  ctrl_t  ctrl;
  word_t  pc;
  word_t  rs1_data;
  word_t  rs2_data;
  word_t  alu_result;
  word_t  next_pc;
  word_t  link;
  rf_wr_t rf_wr;
  logic   retire;

  assign insn      = imem_rdata; // Valid through EXEC and LOAD
  assign imem_addr = pc;

  rv_decode decode_inst (
    .insn (insn),
    .ctrl (ctrl)
  );

  rv_regfile regfile_inst (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (ctrl.rs1),
    .rs2_addr (ctrl.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr       (rf_wr)
  );

  rv_execute execute_inst (
    .ctrl       (ctrl),
    .pc         (pc),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .alu_result (alu_result),
    .next_pc    (next_pc),
    .link       (link)
  );

  rv_sequencer sequencer_inst (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (ctrl),
    .alu_result (alu_result),
    .next_pc    (next_pc),
    .link       (link),
    .rs2_data   (rs2_data),
    .dmem_rdata (dmem_rdata),
    .pc         (pc),
    .rf_wr      (rf_wr),
    .dmem_req   (dmem_req),
    .retire     (retire),
    .halt       (halt)
  );

  rv_perf_counters counters_inst (
    .clk         (clk),
    .rst         (rst),
    .halt        (halt),
    .retire      (retire),
    .cycle_count (cycle_count),
    .insn_count  (insn_count)
  );

endmodule

//--- tb_rv_mem.sv
module tb_rv_mem (
  input  logic              clk,
  input  rv_pkg::word_t     imem_addr,
  output rv_pkg::word_t     imem_rdata,
  input  rv_pkg::dmem_req_t dmem_req,
  output rv_pkg::word_t     dmem_rdata
);
  timeunit 1ns;
  timeprecision 1ns;
  import rv_pkg::*;

  localparam int DEPTH = 256; // 1 KiB with program low and results at 0x100

  word_t mem [DEPTH];

  initial begin
    imem_rdata = '0;
    dmem_rdata = '0;
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = 32'hc0de0000 ^ (i << 2); // Unused words carry their own address
    end
    mem[0]  = 32'h123450b7; // lui   x1, 0x12345
    mem[1]  = 32'h10000113; // addi  x2, x0, 0x100
    mem[2]  = 32'h67808193; // addi  x3, x1, 0x678
    mem[3]  = 32'h00312023; // sw    x3, 0(x2)
    mem[4]  = 32'hffb00213; // addi  x4, x0, -5
    mem[5]  = 32'h003222b3; // slt   x5, x4, x3
    mem[6]  = 32'h00323333; // sltu  x6, x4, x3
    mem[7]  = 32'h40125393; // srai  x7, x4, 1
    mem[8]  = 32'h40118433; // sub   x8, x3, x1
    mem[9]  = 32'h00512223; // sw    x5, 4(x2)
    mem[10] = 32'h00612423; // sw    x6, 8(x2)
    mem[11] = 32'h00712623; // sw    x7, 12(x2)
    mem[12] = 32'h00812823; // sw    x8, 16(x2)
    mem[13] = 32'h00001517; // auipc x10, 1
    mem[14] = 32'h00a12a23; // sw    x10, 20(x2)
    mem[15] = 32'h00628463; // beq   x5, x6, +8 (not taken)
    mem[16] = 32'h00629463; // bne   x5, x6, +8 (taken)
    mem[17] = 32'hbad00613; // addi  x12, x0, 0xbad
    mem[18] = 32'h00324463; // blt   x4, x3, +8 (taken)
    mem[19] = 32'hbad00613;
    mem[20] = 32'h00326463; // bltu  x4, x3, +8 (not taken)
    mem[21] = 32'h01100693; // addi  x13, x0, 0x11
    mem[22] = 32'h00025463; // bge   x4, x0, +8 (not taken)
    mem[23] = 32'h00327463; // bgeu  x4, x3, +8 (taken)
    mem[24] = 32'hbad00613;
    mem[25] = 32'h00c686b3; // add   x13, x13, x12
    mem[26] = 32'h00d12c23; // sw    x13, 24(x2)
    mem[27] = 32'h00c12e23; // sw    x12, 28(x2)
    mem[28] = 32'h00c0076f; // jal   x14, +12
    mem[29] = 32'hbad00613;
    mem[30] = 32'hbad00613;
    mem[31] = 32'h02e12023; // sw    x14, 32(x2)
    mem[32] = 32'h09400793; // addi  x15, x0, 148
    mem[33] = 32'h00178867; // jalr  x16, 1(x15) lands on 148
    mem[34] = 32'hbad00613;
    mem[35] = 32'hbad00613;
    mem[36] = 32'hbad00613;
    mem[37] = 32'h03012223; // sw    x16, 36(x2)
    mem[38] = 32'h00012883; // lw    x17, 0(x2)
    mem[39] = 32'h00188893; // addi  x17, x17, 1
    mem[40] = 32'h03112423; // sw    x17, 40(x2)
    mem[41] = 32'h0ff0000f; // fence
    mem[42] = 32'h02c12623; // sw    x12, 44(x2)
    mem[43] = 32'h05500013; // addi  x0, x0, 0x55 (write to x0 is dropped)
    mem[44] = 32'h00000073; // ecall
  end

  // One-cycle synchronous ports sharing one array
  always @(posedge clk) begin
    imem_rdata <= mem[imem_addr[9:2]];
    if (dmem_req.re) begin
      dmem_rdata <= mem[dmem_req.addr[9:2]];
    end
    if (dmem_req.we) begin
      mem[dmem_req.addr[9:2]] <= dmem_req.wdata;
    end
  end

endmodule

//--- tb_rv_core.sv
module tb_rv_core;
  timeunit 1ns;
  timeprecision 1ns;
  import rv_pkg::*;

  localparam int    NUM_STORES = 12;
  localparam int    N_INSNS    = 37;
  localparam int    N_LOADS    = 1;
  localparam int    MAX_CYCLES = 8 + 4 * N_INSNS;
  localparam word_t POISON     = 32'hfffffbad; // addi x12, x0, 0xbad on dead paths

  // Expected stores worked out by hand from the program
  localparam word_t EXP_ADDR [NUM_STORES] = '{
    32'h100, 32'h104, 32'h108, 32'h10c, 32'h110, 32'h114,
    32'h118, 32'h11c, 32'h120, 32'h124, 32'h128, 32'h12c
  };
  localparam word_t EXP_DATA [NUM_STORES] = '{
    32'h12345678, // lui + addi
    32'h00000001, // slt -5 < x3
    32'h00000000, // sltu
    32'hfffffffd, // srai -5 by 1
    32'h00000678, // sub
    32'h00001034, // auipc at 0x34
    32'h00000011, // branch path result
    32'h00000000, // x12 untouched
    32'h00000074, // jal link
    32'h00000088, // jalr link
    32'h12345679, // load, add one, store again
    32'h00000000
  };

  logic      clk;
  logic      rst;
  word_t     imem_addr;
  word_t     imem_rdata;
  dmem_req_t dmem_req;
  word_t     dmem_rdata;
  logic      halt;
  word_t     cycle_count;
  word_t     insn_count;

  int errors;
  int store_idx;
  int cycles;
  logic timed_out;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  rv_core rv_core_inst (
    .clk         (clk),
    .rst         (rst),
    .imem_addr   (imem_addr),
    .imem_rdata  (imem_rdata),
    .dmem_req    (dmem_req),
    .dmem_rdata  (dmem_rdata),
    .halt        (halt),
    .cycle_count (cycle_count),
    .insn_count  (insn_count)
  );

  tb_rv_mem mem_inst (
    .clk        (clk),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (!rst && dmem_req.we) begin
      store_idx <= store_idx + 1;
    end
  end

  // Reset values during reset and one cycle after
  a_reset_vals : assert property (@(posedge clk)
    $past(rst) |-> (!halt && !dmem_req.we && !dmem_req.re &&
                    cycle_count == '0 && insn_count == '0))
    else begin
      errors++;
      $display("Outputs not at their reset values at cycle %0d", cycles);
    end

  a_store_count : assert property (@(posedge clk) disable iff (rst)
    dmem_req.we |-> store_idx < NUM_STORES)
    else begin
      errors++;
      $display("More stores than expected");
    end

  a_store_addr : assert property (@(posedge clk) disable iff (rst)
    (dmem_req.we && store_idx < NUM_STORES) |-> dmem_req.addr == EXP_ADDR[store_idx])
    else begin
      errors++;
      $display("ERR dmem_req.addr got %h expected %h", $sampled(dmem_req.addr),
               EXP_ADDR[$sampled(store_idx)]);
    end

  a_store_data : assert property (@(posedge clk) disable iff (rst)
    (dmem_req.we && store_idx < NUM_STORES) |-> dmem_req.wdata == EXP_DATA[store_idx])
    else begin
      errors++;
      $display("ERR dmem_req.wdata got %h expected %h", $sampled(dmem_req.wdata),
               EXP_DATA[$sampled(store_idx)]);
    end

  a_no_poison : assert property (@(posedge clk) disable iff (rst)
    dmem_req.we |-> dmem_req.wdata != POISON)
    else begin
      errors++;
      $display("An instruction on a skipped path was executed");
    end

  a_halt_hold : assert property (@(posedge clk) disable iff (rst)
    halt |=> (halt && $stable(imem_addr)))
    else begin
      errors++;
      $display("Core left the halted state or the PC moved after ECALL");
    end

  initial begin
    rst       = 1'b1;
    errors    = 0;
    store_idx = 0;
    cycles    = 0;
    timed_out = 1'b0;
    repeat (8) @(posedge clk);
    #2 rst = 1'b0;
    while (!halt && cycles < MAX_CYCLES) begin
      @(posedge clk);
      #2;
    end
    if (!halt) begin
      timed_out = 1'b1;
      errors++;
      $display("Timeout, core did not halt within %0d cycles", MAX_CYCLES);
    end else begin
      repeat (3) @(posedge clk); // Let the halt checks run a few cycles
      #2;
      a_insn_count : assert (insn_count == N_INSNS)
        else begin
          errors++;
          $display("ERR insn_count got %h expected %h", insn_count, N_INSNS);
        end
      a_cycle_count : assert (cycle_count == 2 * N_INSNS + N_LOADS)
        else begin
          errors++;
          $display("ERR cycle_count got %h expected %h", cycle_count,
                   2 * N_INSNS + N_LOADS);
        end
      a_all_stored : assert (store_idx == NUM_STORES)
        else begin
          errors++;
          $display("Only %0d of %0d expected stores happened", store_idx, NUM_STORES);
        end
    end
    $display("Errors: %0d, stores seen: %0d of %0d, timeout: %0d",
             errors, store_idx, NUM_STORES, timed_out);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- filelist.f
rv_pkg.sv
rv_regfile.sv
rv_decode.sv
rv_execute.sv
rv_sequencer.sv
rv_perf_counters.sv
rv_core.sv
tb_rv_mem.sv
tb_rv_core.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the RV32I core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_core \
  -f filelist.f -o sim \
  && ./obj_dir/sim | tee /dev/stderr | grep -q "^STATUS: PASS$" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
